//--- tb.f
source/split_pkg.sv
source/tcdm_if.sv
source/split_ctrl.sv
source/chan_queue.sv
source/tcdm_bank.sv
source/wide_split_top.sv
bench/tb_wide_split.sv

//--- Makefile
# Verilator build and run of the wide splitter testbench

VERILATOR ?= verilator
TOP       ?= tb_wide_split
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0

SOURCES := $(shell cat $(FILELIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -qx 'NO ERRORS' $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/tb_wide_split.sv
`timescale 1ns/1ps

// directed tests for the 64-bit to 2x32-bit tcdm splitter
module tb_wide_split import split_pkg::*; ();

  localparam int unsigned SEED       = 32'hbb1ff34f;
  localparam int          CLK_HALF   = 20;                          // 40 ns period
  localparam int          N_TXN      = 1 + 32 + 8 + 6 + 12 + 200;  // wide requests over all tests
  localparam int          TXN_BOUND  = 50;                          // cycles allowed per request
  localparam int          INIT_WORDS = 16;  // words written by the full-word test

  logic       clk_i;
  logic       rst_ni;
  logic       req_i;
  logic       gnt_o;
  addr_t      add_i;
  logic       wen_i;
  wide_be_t   be_i;
  wide_data_t data_i;
  logic       r_valid_o;
  logic       r_ready_i;
  wide_data_t r_data_o;
  chan_mask_t bank_stall_i;

  wide_data_t model [BANK_WORDS];  // reference memory with one wide word per index
  wide_data_t exp_q [$];           // responses still owed in grant order
  int         errors;
  int         checks;
  int         cur_idx;             // word index of the request on the port
  int         ready_mode;          // 0 always ready, 1 held low, 2 random gaps
  logic       stall_rand;          // random bank stalls instead of stall_fix
  chan_mask_t stall_fix;
  logic       mon_on;
  logic       hold_pending;        // response was offered and not taken
  wide_data_t hold_data;
  wide_data_t mon_exp;

  wide_split_top uut (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_i        (req_i),
    .gnt_o        (gnt_o),
    .add_i        (add_i),
    .wen_i        (wen_i),
    .be_i         (be_i),
    .data_i       (data_i),
    .r_valid_o    (r_valid_o),
    .r_ready_i    (r_ready_i),
    .r_data_o     (r_data_o),
    .bank_stall_i (bank_stall_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_HALF) clk_i = ~clk_i;
  end

  // ready and stall pattern driven on every rising edge
  initial begin
    r_ready_i    = 1'b1;
    bank_stall_i = '0;
    forever begin
      @(posedge clk_i);
      case (ready_mode)
        0:       r_ready_i <= 1'b1;
        1:       r_ready_i <= 1'b0;
        default: r_ready_i <= ($urandom_range(3) != 0);  // roughly one gap in four
      endcase
      bank_stall_i <= stall_rand ? {($urandom_range(3) == 0), ($urandom_range(3) == 0)}
                                 : stall_fix;
    end
  end

  task automatic report_fail(input string msg);
    errors++;
    $display("[FAIL] %0t: %s", $time, msg);
  endtask

  task automatic check_cond(input logic cond, input string msg);
    checks++;
    assert (cond) else report_fail(msg);
  endtask

  // response monitor samples in the middle of the cycle
  always @(negedge clk_i) begin
    if (mon_on) begin
      if (hold_pending) begin
        checks++;
        assert (r_valid_o && r_data_o === hold_data)
          else report_fail($sformatf("held response moved, valid %b data %h, was %h",
                                     r_valid_o, r_data_o, hold_data));
      end
      hold_pending = r_valid_o && !r_ready_i;
      hold_data    = r_data_o;
      if (r_valid_o && r_ready_i) begin
        checks++;
        assert (exp_q.size() != 0)
          else begin
            errors++;
            $display("error at %0t: a response came back with no request outstanding", $time);
          end
        if (exp_q.size() != 0) begin
          mon_exp = exp_q.pop_front();
          checks++;
          assert (r_data_o === mon_exp)
            else report_fail($sformatf("response %h, expected %h", r_data_o, mon_exp));
        end
      end
    end
  end

  function automatic wide_data_t rand_word();
    return {$urandom(), $urandom()};
  endfunction

  // payload stays on the port until the grant
  task automatic drive_req(input logic wen, input int idx, input wide_be_t be,
                           input wide_data_t data);
    @(posedge clk_i);
    cur_idx = idx;
    req_i  <= 1'b1;
    wen_i  <= wen;
    add_i  <= addr_t'(idx * 8);  // wide words are 8-byte aligned
    be_i   <= be;
    data_i <= data;
  endtask

  // wait for gnt_o, then update the model and queue the expected response
  task automatic take_grant(output int waited);
    wide_data_t word;
    waited = 0;
    @(negedge clk_i);
    while (!gnt_o) begin
      waited++;
      @(negedge clk_i);
    end
    word = model[cur_idx];
    if (wen_i) begin
      for (int b = 0; b < 8; b++) begin
        if (be_i[b]) word[8*b +: 8] = data_i[8*b +: 8];
      end
      model[cur_idx] = word;  // write answers with the merged word
    end
    exp_q.push_back(word);
  endtask

  task automatic issue(input logic wen, input int idx, input wide_be_t be,
                       input wide_data_t data);
    int waited;
    drive_req(wen, idx, be, data);
    take_grant(waited);
  endtask

  // drop req and wait until every owed response is back
  task automatic drain();
    @(posedge clk_i);
    req_i <= 1'b0;
    while (exp_q.size() != 0) @(negedge clk_i);
    @(negedge clk_i);
  endtask

  task automatic test_reset_state();
    int waited;
    check_cond(!r_valid_o, "r_valid_o high after reset");
    drive_req(1'b1, 0, '1, 64'h0123_4567_89ab_cdef);
    take_grant(waited);
    check_cond(waited == 0, $sformatf("first grant took %0d extra cycles", waited));
    drain();
  endtask

  task automatic test_full_words();
    for (int i = 0; i < INIT_WORDS; i++) issue(1'b1, i, '1, rand_word());
    for (int i = 0; i < INIT_WORDS; i++) issue(1'b0, i, '0, '0);
    drain();
  endtask

  task automatic test_byte_enables();
    int       idx [4] = '{2, 5, 9, 12};
    wide_be_t msk [4] = '{8'h0f, 8'hf0, 8'ha5, 8'h3c};
    for (int i = 0; i < 4; i++) issue(1'b1, idx[i], msk[i], rand_word());
    for (int i = 0; i < 4; i++) issue(1'b0, idx[i], '0, '0);
    drain();
  endtask

  // channel 1 stalled so its queue fills and the third wide request waits
  task automatic test_bank_stall();
    int waited;
    stall_fix = 2'b10;
    issue(1'b1, 20, '1, rand_word());
    issue(1'b1, 21, '1, rand_word());
    drive_req(1'b1, 22, '1, rand_word());
    repeat (8) begin
      @(negedge clk_i);
      check_cond(!gnt_o, "gnt_o high while channel 1 is stalled with a full queue");
    end
    stall_fix = '0;
    take_grant(waited);
    for (int i = 20; i < 23; i++) issue(1'b0, i, '0, '0);
    drain();
  endtask

  // each channel holds 2 queue entries + 1 bank register + 2 queue entries so the 6th waits
  task automatic test_backpressure();
    int waited;
    ready_mode = 1;
    for (int i = 24; i < 29; i++) issue(1'b1, i, '1, rand_word());
    drive_req(1'b1, 29, '1, rand_word());
    repeat (12) begin
      @(negedge clk_i);
      check_cond(!gnt_o, "gnt_o high with every queue full");
    end
    check_cond(r_valid_o, "no response offered while r_ready_i is low");
    ready_mode = 0;
    take_grant(waited);
    for (int i = 24; i < 30; i++) issue(1'b0, i, '0, '0);
    drain();
  endtask

  task automatic test_random_burst();
    ready_mode = 2;
    stall_rand = 1'b1;
    for (int n = 0; n < 200; n++) begin
      issue(($urandom_range(1) == 1), int'($urandom_range(INIT_WORDS - 1)),
            wide_be_t'($urandom()), rand_word());
    end
    stall_rand = 1'b0;
    ready_mode = 0;
    drain();
  endtask

  initial begin
    void'($urandom(SEED));
    errors       = 0;
    checks       = 0;
    cur_idx      = 0;
    ready_mode   = 0;
    stall_rand   = 1'b0;
    stall_fix    = '0;
    mon_on       = 1'b0;
    hold_pending = 1'b0;
    hold_data    = '0;
    rst_ni       = 1'b0;
    req_i        = 1'b0;
    wen_i        = 1'b0;
    add_i        = '0;
    be_i         = '0;
    data_i       = '0;
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    mon_on = 1'b1;
    test_reset_state();
    test_full_words();
    test_byte_enables();
    test_bank_stall();
    test_backpressure();
    test_random_burst();
    $display("checks: %0d  errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  // watchdog sized from the request count
  initial begin
    #(N_TXN * TXN_BOUND * 2 * CLK_HALF);
    $display("timeout: the tests did not finish within %0d cycles", N_TXN * TXN_BOUND);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

//--- source/wide_split_top.sv
`timescale 1ns/1ps

// 64-bit port split into two 32-bit channels, each with its own queue and bank
module wide_split_top import split_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       req_i,
  output logic       gnt_o,
  input  addr_t      add_i,
  input  logic       wen_i,         // high = write
  input  wide_be_t   be_i,
  input  wide_data_t data_i,
  output logic       r_valid_o,
  input  logic       r_ready_i,
  output wide_data_t r_data_o,
  input  chan_mask_t bank_stall_i   // one stall per bank
);

  tcdm_if chan_up   [NB_CHAN] ();  // splitter to queue
  tcdm_if chan_bank [NB_CHAN] ();  // queue to bank

  // handshakes of every channel, plus the response join
  split_ctrl u_ctrl (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .req_i     (req_i),
    .gnt_o     (gnt_o),
    .r_valid_o (r_valid_o),
    .r_ready_i (r_ready_i),
    .chan      (chan_up)
  );

  for (genvar k = 0; k < NB_CHAN; k++) begin : g_chan
    // channel k serves the narrow word at add_i + 4*k
    assign chan_up[k].add  = add_i + addr_t'(NARROW_BW * k);
    assign chan_up[k].wen  = wen_i;
    assign chan_up[k].be   = be_i[k*NARROW_BW +: NARROW_BW];
    assign chan_up[k].data = data_i[k*NARROW_DW +: NARROW_DW];

    assign r_data_o[k*NARROW_DW +: NARROW_DW] = chan_up[k].r_data;  // channel 0 low

    chan_queue u_queue (
      .clk_i  (clk_i),
      .rst_ni (rst_ni),
      .up     (chan_up[k]),
      .down   (chan_bank[k])
    );

    tcdm_bank u_bank (
      .clk_i   (clk_i),
      .rst_ni  (rst_ni),
      .stall_i (bank_stall_i[k]),
      .port    (chan_bank[k])
    );
  end

endmodule

//--- source/tcdm_bank.sv
`timescale 1ns/1ps

// single-port 32-bit bank, one response register, stall from outside
module tcdm_bank import split_pkg::*; (
  input  logic   clk_i,
  input  logic   rst_ni,
  input  logic   stall_i,   // contention from the interconnect
  tcdm_if.target port
);

  narrow_data_t mem_q [BANK_WORDS];
  bank_idx_t    idx;
  narrow_data_t wr_word;       // stored word merged with enabled bytes
  narrow_data_t rdata_q;
  logic         rvalid_q;
  logic         grant;

  // word index inside the channel since channels differ only in bit 2
  assign idx = port.add[BANK_AW+2:3];

  // accept while free, or while the pending response leaves this cycle
  assign grant    = port.req & ~stall_i & (~rvalid_q | port.r_ready);
  assign port.gnt = grant;

  always_comb begin
    wr_word = mem_q[idx];
    for (int b = 0; b < NARROW_BW; b++) begin
      if (port.be[b]) wr_word[8*b +: 8] = port.data[8*b +: 8];
    end
  end

  always_ff @(posedge clk_i) begin
    if (grant) begin
      if (port.wen) mem_q[idx] <= wr_word;
      rdata_q <= port.wen ? wr_word : mem_q[idx];  // write returns the new word
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
    end else if (grant) begin
      rvalid_q <= 1'b1;
    end else if (port.r_ready) begin
      rvalid_q <= 1'b0;  // response taken with nothing new behind it
    end
  end

  assign port.r_valid = rvalid_q;
  assign port.r_data  = rdata_q;

  // held response keeps its data until taken
  a_rdata_stable: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    port.r_valid && !port.r_ready |=> port.r_valid && $stable(port.r_data)
  );

endmodule

//--- source/chan_queue.sv
`timescale 1ns/1ps

// per-channel request and response queues between splitter and bank
module chan_queue import split_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  tcdm_if.target    up,    // splitter side
  tcdm_if.initiator down   // bank side
);

  // request queue storage
  addr_t        req_add_q  [QUEUE_DEPTH];
  logic         req_wen_q  [QUEUE_DEPTH];
  narrow_be_t   req_be_q   [QUEUE_DEPTH];
  narrow_data_t req_data_q [QUEUE_DEPTH];
  qptr_t        req_wptr_q, req_rptr_q;
  qcnt_t        req_cnt_q;
  logic         req_push, req_pop;

  // response queue storage
  narrow_data_t rsp_data_q [QUEUE_DEPTH];
  qptr_t        rsp_wptr_q, rsp_rptr_q;
  qcnt_t        rsp_cnt_q;
  logic         rsp_push, rsp_pop;

  function automatic qptr_t ptr_next(input qptr_t ptr);
    ptr_next = (ptr == qptr_t'(QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign up.gnt   = (req_cnt_q != qcnt_t'(QUEUE_DEPTH));  // grant on a free slot alone
  assign req_push = up.req & up.gnt;
  assign req_pop  = down.req & down.gnt;

  // head entry towards the bank
  assign down.req  = (req_cnt_q != '0);
  assign down.add  = req_add_q[req_rptr_q];
  assign down.wen  = req_wen_q[req_rptr_q];
  assign down.be   = req_be_q[req_rptr_q];
  assign down.data = req_data_q[req_rptr_q];

  assign down.r_ready = (rsp_cnt_q != qcnt_t'(QUEUE_DEPTH));
  assign rsp_push     = down.r_valid & down.r_ready;
  assign up.r_valid   = (rsp_cnt_q != '0);
  assign up.r_data    = rsp_data_q[rsp_rptr_q];
  assign rsp_pop      = up.r_valid & up.r_ready;

  always_ff @(posedge clk_i) begin
    if (req_push) begin
      req_add_q[req_wptr_q]  <= up.add;
      req_wen_q[req_wptr_q]  <= up.wen;
      req_be_q[req_wptr_q]   <= up.be;
      req_data_q[req_wptr_q] <= up.data;
    end
    if (rsp_push) rsp_data_q[rsp_wptr_q] <= down.r_data;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_wptr_q <= '0;
      req_rptr_q <= '0;
      req_cnt_q  <= '0;
      rsp_wptr_q <= '0;
      rsp_rptr_q <= '0;
      rsp_cnt_q  <= '0;
    end else begin
      if (req_push) req_wptr_q <= ptr_next(req_wptr_q);
      if (req_pop)  req_rptr_q <= ptr_next(req_rptr_q);
      if (req_push && !req_pop)      req_cnt_q <= req_cnt_q + 1'b1;
      else if (!req_push && req_pop) req_cnt_q <= req_cnt_q - 1'b1;
      if (rsp_push) rsp_wptr_q <= ptr_next(rsp_wptr_q);
      if (rsp_pop)  rsp_rptr_q <= ptr_next(rsp_rptr_q);
      if (rsp_push && !rsp_pop)      rsp_cnt_q <= rsp_cnt_q + 1'b1;
      else if (!rsp_push && rsp_pop) rsp_cnt_q <= rsp_cnt_q - 1'b1;
    end
  end

  // occupancy of either queue never goes past its depth
  a_no_push_full: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    req_cnt_q <= qcnt_t'(QUEUE_DEPTH) && rsp_cnt_q <= qcnt_t'(QUEUE_DEPTH)
  );

endmodule

//--- source/split_ctrl.sv
`timescale 1ns/1ps

// wide grant and response join across the narrow channels
// channel payload comes from the top and only handshakes live here
module split_ctrl import split_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      req_i,      // wide request
  output logic      gnt_o,      // wide grant
  output logic      r_valid_o,  // joined response valid
  input  logic      r_ready_i,
  tcdm_if.initiator chan [NB_CHAN]
);

  gnt_state_e state_q, state_d;
  chan_mask_t mask_q, mask_d;   // channels that already took the current request

  chan_mask_t chan_req;         // masked channel requests
  chan_mask_t chan_gnt;         // raw queue grants independent of req
  chan_mask_t chan_acc;         // channels accepting this cycle
  chan_mask_t chan_rvalid;
  logic       all_done;         // every channel granted now or earlier
  logic       rsp_pop;          // all queues pop together

  // in partial state only the channels still missing are requested
  assign chan_req = (state_q == GNT_PARTIAL) ? ({NB_CHAN{req_i}} & ~mask_q)
                                             : {NB_CHAN{req_i}};
  assign chan_acc = chan_req & chan_gnt;
  assign all_done = &(chan_acc | mask_q);
  assign gnt_o    = req_i & all_done;

  // response joins once every queue holds its half
  assign r_valid_o = &chan_rvalid;
  assign rsp_pop   = r_valid_o & r_ready_i;

  for (genvar k = 0; k < NB_CHAN; k++) begin : g_bind
    assign chan[k].req     = chan_req[k];
    assign chan[k].r_ready = rsp_pop;   // same ready on every channel
    assign chan_gnt[k]     = chan[k].gnt;
    assign chan_rvalid[k]  = chan[k].r_valid;
  end

  always_comb begin
    state_d = state_q;
    mask_d  = mask_q;
    unique case (state_q)
      GNT_IDLE: begin
        if (req_i && !all_done) begin  // only part of the channels took it
          state_d = GNT_PARTIAL;
          mask_d  = chan_acc;
        end
      end
      GNT_PARTIAL: begin
        if (all_done) begin            // last channels granted so the wide gnt goes out
          state_d = GNT_IDLE;
          mask_d  = '0;
        end else begin
          mask_d  = mask_q | chan_acc;
        end
      end
      default: begin
        state_d = GNT_IDLE;
        mask_d  = '0;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= GNT_IDLE;
      mask_q  <= '0;
    end else begin
      state_q <= state_d;
      mask_q  <= mask_d;
    end
  end

  // a channel that took the request without the wide grant sits out the next cycle
  a_no_double_grant: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !gnt_o |=> (chan_acc & $past(chan_acc)) == '0
  );

  // a wide request not yet granted stays up until the wide grant
  a_req_held: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    req_i && !gnt_o |=> req_i
  );

endmodule

//--- source/tcdm_if.sv
`timescale 1ns/1ps

// narrow tcdm channel, one 32-bit word per transfer
// request moves on req & gnt, response moves on r_valid & r_ready
interface tcdm_if import split_pkg::*; ();

  logic         req;
  logic         gnt;
  addr_t        add;      // byte address
  logic         wen;      // high = write, low = read
  narrow_be_t   be;
  narrow_data_t data;
  logic         r_valid;
  logic         r_ready;
  narrow_data_t r_data;   // read word, or merged word after a write

  // request side
  modport initiator (
    output req,
    output add,
    output wen,
    output be,
    output data,
    output r_ready,
    input  gnt,
    input  r_valid,
    input  r_data
  );

  // memory side
  modport target (
    input  req,
    input  add,
    input  wen,
    input  be,
    input  data,
    input  r_ready,
    output gnt,
    output r_valid,
    output r_data
  );

endinterface

//--- source/split_pkg.sv
package split_pkg;

  // channel split of the wide port
  localparam int unsigned NB_CHAN   = 2;
  localparam int unsigned WIDE_DW   = 64;
  localparam int unsigned NARROW_DW = 32;
  localparam int unsigned NARROW_BW = 4;  // byte enables per channel
  localparam int unsigned ADDR_W    = 32;

  // memory side
  localparam int unsigned BANK_WORDS = 256;
  localparam int unsigned BANK_AW    = $clog2(BANK_WORDS);  // word index bits

  // per-channel queues
  localparam int unsigned QUEUE_DEPTH = 2;
  localparam int unsigned QPTR_W      = $clog2(QUEUE_DEPTH);
  localparam int unsigned QCNT_W      = $clog2(QUEUE_DEPTH + 1);  // count reaches depth

  typedef logic [ADDR_W-1:0]            addr_t;       // byte address
  typedef logic [WIDE_DW-1:0]           wide_data_t;
  typedef logic [NB_CHAN*NARROW_BW-1:0] wide_be_t;
  typedef logic [NARROW_DW-1:0]         narrow_data_t;
  typedef logic [NARROW_BW-1:0]         narrow_be_t;
  typedef logic [NB_CHAN-1:0]           chan_mask_t;  // one bit per channel
  typedef logic [BANK_AW-1:0]           bank_idx_t;
  typedef logic [QPTR_W-1:0]            qptr_t;
  typedef logic [QCNT_W-1:0]            qcnt_t;

  // grant fsm of the splitter
  typedef enum logic {
    GNT_IDLE,     // all channels follow the wide req
    GNT_PARTIAL   // some channels already took the current request
  } gnt_state_e;

endpackage
